// File: verilog/aes_pkg.sv
package aes_pkg;

    typedef logic [127:0] block_t;
    typedef logic [31:0]  word_t;
    typedef logic [7:0]   byte_t;

    localparam int NUM_ROUNDS   = 10;
    // Whitening register plus two cycles per round
    localparam int PIPE_LATENCY = 1 + 2 * NUM_ROUNDS;

    //////////////////////////////
    // Forward S-box, entry 0 is the leftmost byte of the first row
    localparam byte_t [0:255] SBOX = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    //////////////////////////////
    // Round constants, one per key expansion stage
    localparam byte_t [0:NUM_ROUNDS-1] RCON = {
        8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
        8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

    // Multiply by x modulo x^8 + x^4 + x^3 + x + 1
    function automatic byte_t xtime(input byte_t b);
        byte_t shifted;
        shifted = {b[6:0], 1'b0};
        if (b[7]) begin
            shifted = shifted ^ 8'h1b;
        end
        return shifted;
    endfunction

endpackage

// File: verilog/leak_pkg.sv
package leak_pkg;

    typedef logic [19:0] lfsr_t;
    typedef logic [63:0] leak_t;

    // Low key bits that reach the leak register
    localparam int LEAK_KEY_BITS = 8;
    // Each bit fans out to one byte
    localparam int LEAK_COPIES   = 8;

    //////////////////////////////
    // x^20 + x^13 + x^9 + x^5 + 1, shifting right
    localparam lfsr_t LFSR_SEED = 20'h99999;
    // Taps at bits 15, 11, 7 and 0
    localparam lfsr_t LFSR_TAPS = 20'h08881;

    // Plaintext that arms the trigger
    localparam logic [127:0] TRIGGER_PT = 128'h0011_2233_4455_6677_8899_aabb_ccdd_eeff;

endpackage

// File: verilog/sub_word.sv
`timescale 1ns/1ns

module sub_word (
    input  logic           clk,
    input  aes_pkg::word_t in,
    output aes_pkg::word_t out
);

    import aes_pkg::*;

    // Four byte lookups, registered together
    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            out[8*b +: 8] <= SBOX[in[8*b +: 8]];
        end
    end

endmodule

// File: verilog/key_expand_stage.sv
`timescale 1ns/1ns

module key_expand_stage #(
    parameter int RCON_IDX = 0
) (
    input  logic            clk,
    input  aes_pkg::block_t in,
    output aes_pkg::block_t out_reg,
    output aes_pkg::block_t out_now
);

    import aes_pkg::*;

    word_t prefix   [4];
    word_t prefix_q [4];
    word_t sub_q;

    //////////////////////////////
    // Cycle one

    // Round constant on word 0, then running XOR across the words
    always_comb begin
        prefix[0] = in[127:96] ^ {RCON[RCON_IDX], 24'h000000};
        for (int i = 1; i < 4; i++) begin
            prefix[i] = prefix[i-1] ^ in[127 - 32*i -: 32];
        end
    end

    always_ff @(posedge clk) begin
        prefix_q <= prefix;
    end

    // RotWord of the last word goes through the S-box in parallel
    sub_word u_sub (
        .clk (clk),
        .in  ({in[23:0], in[31:24]}),
        .out (sub_q)
    );

    //////////////////////////////
    // Cycle two
    assign out_now = {prefix_q[0] ^ sub_q, prefix_q[1] ^ sub_q,
                      prefix_q[2] ^ sub_q, prefix_q[3] ^ sub_q};

    always_ff @(posedge clk) begin
        out_reg <= out_now;
    end

endmodule

// File: verilog/cipher_round.sv
`timescale 1ns/1ns

module cipher_round #(
    parameter bit LAST_ROUND = 1'b0
) (
    input  logic            clk,
    input  aes_pkg::block_t state_in,
    input  aes_pkg::block_t round_key,
    output aes_pkg::block_t state_out
);

    import aes_pkg::*;

    word_t  sub_col [4];
    block_t next_state;

    //////////////////////////////
    // SubBytes, one registered word per column
    for (genvar c = 0; c < 4; c++) begin : g_col
        sub_word u_sub (
            .clk (clk),
            .in  (state_in[127 - 32*c -: 32]),
            .out (sub_col[c])
        );
    end

    //////////////////////////////
    // ShiftRows and MixColumns
    always_comb begin
        byte_t a  [4];
        byte_t a2 [4];
        for (int c = 0; c < 4; c++) begin
            // Row r of new column c comes from column c + r
            for (int r = 0; r < 4; r++) begin
                a[r]  = sub_col[(c + r) % 4][31 - 8*r -: 8];
                a2[r] = xtime(a[r]);
            end
            if (LAST_ROUND) begin
                next_state[127 - 32*c -: 32] = {a[0], a[1], a[2], a[3]};
            end else begin
                // 3a is 2a ^ a
                next_state[127 - 32*c -: 32] = {
                    a2[0] ^ a2[1] ^ a[1] ^ a[2] ^ a[3],
                    a[0] ^ a2[1] ^ a2[2] ^ a[2] ^ a[3],
                    a[0] ^ a[1] ^ a2[2] ^ a2[3] ^ a[3],
                    a2[0] ^ a[0] ^ a[1] ^ a[2] ^ a2[3]
                };
            end
        end
    end

    // AddRoundKey, key arrives straight from the key stage this cycle
    always_ff @(posedge clk) begin
        state_out <= next_state ^ round_key;
    end

endmodule

// File: verilog/aes_128_pipe.sv
`timescale 1ns/1ns

module aes_128_pipe (
    input  logic            clk,
    input  aes_pkg::block_t state,
    input  aes_pkg::block_t key,
    output aes_pkg::block_t out
);

    import aes_pkg::*;

    block_t state_chain [0:NUM_ROUNDS];
    block_t key_chain   [0:NUM_ROUNDS-1];
    block_t round_key   [0:NUM_ROUNDS-1];

    // Initial AddRoundKey and key capture
    always_ff @(posedge clk) begin
        state_chain[0] <= state ^ key;
        key_chain[0]   <= key;
    end

    //////////////////////////////
    // Round and key stages side by side
    for (genvar i = 0; i < NUM_ROUNDS; i++) begin : g_round
        if (i < NUM_ROUNDS - 1) begin : g_key
            key_expand_stage #(.RCON_IDX(i)) u_key (
                .clk     (clk),
                .in      (key_chain[i]),
                .out_reg (key_chain[i+1]),
                .out_now (round_key[i])
            );
        end else begin : g_key_last
            // Nothing follows the last key stage
            key_expand_stage #(.RCON_IDX(i)) u_key (
                .clk     (clk),
                .in      (key_chain[i]),
                .out_reg (),
                .out_now (round_key[i])
            );
        end

        cipher_round #(.LAST_ROUND(i == NUM_ROUNDS - 1)) u_round (
            .clk       (clk),
            .state_in  (state_chain[i]),
            .round_key (round_key[i]),
            .state_out (state_chain[i+1])
        );
    end

    assign out = state_chain[NUM_ROUNDS];

endmodule

// File: verilog/leak_channel.sv
`timescale 1ns/1ns

module leak_channel #(
    parameter aes_pkg::block_t TRIGGER = leak_pkg::TRIGGER_PT,
    parameter leak_pkg::lfsr_t SEED    = leak_pkg::LFSR_SEED
) (
    input  logic            clk,
    input  logic            rst,
    input  aes_pkg::block_t state,
    input  aes_pkg::block_t key,
    output leak_pkg::leak_t leak
);

    import leak_pkg::*;

    logic  armed;
    lfsr_t lfsr;
    logic  feedback;

    //////////////////////////////
    // Sticky trigger, cleared only by reset
    always_ff @(posedge clk) begin
        if (rst) begin
            armed <= 1'b0;
        end else if (state == TRIGGER) begin
            armed <= 1'b1;
        end
    end

    // Fibonacci LFSR, runs once armed
    assign feedback = ^(lfsr & LFSR_TAPS);

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= SEED;
        end else if (armed) begin
            lfsr <= {feedback, lfsr[19:1]};
        end
    end

    //////////////////////////////
    // Each low key bit, masked, spread over one byte
    always_ff @(posedge clk) begin
        if (rst) begin
            leak <= '0;
        end else begin
            for (int i = 0; i < LEAK_KEY_BITS; i++) begin
                leak[i*LEAK_COPIES +: LEAK_COPIES] <= {LEAK_COPIES{key[i] ^ lfsr[i]}};
            end
        end
    end

endmodule

// File: verilog/aes_leak_top.sv
`timescale 1ns/1ns

module aes_leak_top #(
    parameter aes_pkg::block_t TRIGGER = leak_pkg::TRIGGER_PT,
    parameter leak_pkg::lfsr_t SEED    = leak_pkg::LFSR_SEED
) (
    input  logic            clk,
    input  logic            rst,
    input  aes_pkg::block_t state,
    input  aes_pkg::block_t key,
    output aes_pkg::block_t out,
    output leak_pkg::leak_t leak
);

    // Cipher datapath, no reset
    aes_128_pipe u_pipe (
        .clk   (clk),
        .state (state),
        .key   (key),
        .out   (out)
    );

    // Leak path watches the raw inputs
    leak_channel #(
        .TRIGGER (TRIGGER),
        .SEED    (SEED)
    ) u_leak (
        .clk   (clk),
        .rst   (rst),
        .state (state),
        .key   (key),
        .leak  (leak)
    );

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD = 40
) (
    output logic clk
);

    // Free running, starts low
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

// File: testbench/tb_aes_leak_top.sv
`timescale 1ns/1ns

module tb_aes_leak_top;

    import aes_pkg::*;
    import leak_pkg::*;

    localparam int     LATENCY        = 21;
    localparam int     TIMEOUT_CYCLES = 400;
    localparam lfsr_t  SEED_VALUE     = 20'h99999;
    localparam block_t TRIG_PT        = 128'h00112233445566778899aabbccddeeff;

    // FIPS-197 appendix B and appendix C.1 vectors
    localparam block_t KEY_B = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    localparam block_t PT_B  = 128'h3243f6a8885a308d313198a2e0370734;
    localparam block_t CT_B  = 128'h3925841d02dc09fbdc118597196a0b32;
    localparam block_t KEY_C = 128'h000102030405060708090a0b0c0d0e0f;
    localparam block_t PT_C  = 128'h00112233445566778899aabbccddeeff;
    localparam block_t CT_C  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

    logic   clk;
    logic   rst;
    block_t state;
    block_t key;
    block_t out;
    leak_t  leak;

    // Leak channel model state
    logic  m_armed;
    lfsr_t m_lfsr;
    leak_t m_leak;

    // Expected ciphertexts indexed by the cycle they are due
    block_t exp_mem   [0:511];
    bit     exp_valid [0:511];
    int     n_scheduled;
    int     n_checked;
    int     tick_count;
    int     cycle_count = 0;

    logic [31:0] rand_state;

    tb_clock #(.PERIOD(40)) u_clock (.clk(clk));

    aes_leak_top u_dut (
        .clk   (clk),
        .rst   (rst),
        .state (state),
        .key   (key),
        .out   (out),
        .leak  (leak)
    );

    //////////////////////////////
    // Reference models

    // Taps 15, 11, 7 and 0 with a right shift
    function automatic lfsr_t lfsr_model_next(input lfsr_t l);
        logic fb;
        fb = l[15] ^ l[11] ^ l[7] ^ l[0];
        return {fb, l[19:1]};
    endfunction

    // Byte i holds eight copies of key bit i masked by LFSR bit i
    function automatic leak_t leak_of(input block_t k, input lfsr_t l);
        leak_t v;
        for (int i = 0; i < 8; i++) begin
            v[8*i +: 8] = {8{k[i] ^ l[i]}};
        end
        return v;
    endfunction

    // What the leak channel does at one edge
    task automatic model_edge(input block_t s, input block_t k, input logic r);
        if (r) begin
            m_armed = 1'b0;
            m_lfsr  = SEED_VALUE;
            m_leak  = '0;
        end else begin
            m_leak = leak_of(k, m_lfsr);
            if (m_armed) begin
                m_lfsr = lfsr_model_next(m_lfsr);
            end
            if (s == TRIG_PT) begin
                m_armed = 1'b1;
            end
        end
    endtask

    // Stimulus LFSR on x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = rand_state[31] ^ rand_state[21] ^ rand_state[1] ^ rand_state[0];
        rand_state = {rand_state[30:0], fb};
        return fb;
    endfunction

    // Never returns the trigger plaintext
    task automatic random_block(output block_t blk);
        do begin
            for (int i = 0; i < 128; i++) begin
                blk = {blk[126:0], lfsr_bit()};
            end
        end while (blk == TRIG_PT);
    endtask

    //////////////////////////////
    // Checking and driving

    task automatic check_value(input block_t actual, input block_t expected,
                               input string msg);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s: got %h, expected %h",
                     $time, msg, actual, expected);
            $display("Simulation failed");
            $fatal(1, "value check failed");
        end
    endtask

    // One clock that drives after the edge and checks at the falling edge
    task automatic apply_cycle(input block_t st, input block_t k, input logic r,
                               input bit has_exp, input block_t exp_ct);
        logic [8:0] due;
        logic [8:0] now_slot;
        @(posedge clk);
        tick_count = tick_count + 1;
        // Inputs still hold what the DUT samples at this edge
        model_edge(state, key, rst);
        state <= st;
        key   <= k;
        rst   <= r;
        if (has_exp) begin
            due            = 9'(tick_count + LATENCY);
            exp_mem[due]   = exp_ct;
            exp_valid[due] = 1'b1;
            n_scheduled    = n_scheduled + 1;
        end
        @(negedge clk);
        check_value({64'h0, leak}, {64'h0, m_leak}, "leak register");
        now_slot = 9'(tick_count);
        if (exp_valid[now_slot]) begin
            check_value(out, exp_mem[now_slot], "ciphertext");
            exp_valid[now_slot] = 1'b0;
            n_checked           = n_checked + 1;
        end
    endtask

    task automatic drain(input block_t k, input int cycles);
        block_t pt;
        for (int i = 0; i < cycles; i++) begin
            random_block(pt);
            apply_cycle(pt, k, 1'b0, 1'b0, '0);
        end
    endtask

    // Reset high for the given number of drives before release
    task automatic hold_reset(input block_t k, input int high_drives);
        block_t pt;
        logic   was_high;
        for (int i = 0; i <= high_drives; i++) begin
            random_block(pt);
            was_high = rst;
            apply_cycle(pt, k, (i < high_drives), 1'b0, '0);
            if (was_high) begin
                check_value({64'h0, leak}, '0, "leak not zero during reset");
            end
        end
    endtask

    //////////////////////////////
    // Directed tests

    task automatic idle_leak();
        block_t k;
        block_t pt;
        leak_t  steady;
        random_block(k);
        // rst is already high from time zero
        hold_reset(k, 3);
        steady = leak_of(k, SEED_VALUE);
        for (int i = 0; i < 16; i++) begin
            random_block(pt);
            apply_cycle(pt, k, 1'b0, 1'b0, '0);
            check_value({64'h0, leak}, {64'h0, steady}, "idle leak left the seed value");
        end
    endtask

    task automatic known_answer();
        int start_checked;
        start_checked = n_checked;
        apply_cycle(PT_B, KEY_B, 1'b0, 1'b1, CT_B);
        drain(KEY_B, LATENCY);
        check_value(block_t'(n_checked - start_checked), block_t'(1),
                    "known answer ciphertext was never compared");
    endtask

    task automatic trigger_run();
        block_t k;
        block_t prev_k;
        block_t pt;
        int     moved;
        moved = 0;
        random_block(k);
        apply_cycle(TRIG_PT, k, 1'b0, 1'b0, '0);
        for (int i = 0; i < 30; i++) begin
            prev_k = k;
            random_block(k);
            random_block(pt);
            apply_cycle(pt, k, 1'b0, 1'b0, '0);
            if (leak != leak_of(prev_k, SEED_VALUE)) begin
                moved = moved + 1;
            end
        end
        // Seed low byte 99 becomes cc after the first shift
        check_value(block_t'(moved != 0), block_t'(1), "LFSR never advanced after trigger");
    endtask

    task automatic rereset();
        block_t k;
        block_t pt;
        random_block(k);
        hold_reset(k, 4);
        for (int i = 0; i < 4; i++) begin
            random_block(pt);
            apply_cycle(pt, k, 1'b0, 1'b0, '0);
            check_value({64'h0, leak}, {64'h0, leak_of(k, SEED_VALUE)},
                        "leak after re-reset not back at the seed value");
        end
        known_answer();
    endtask

    // Vector C doubles as the trigger plaintext
    task automatic pipelining();
        int start_checked;
        start_checked = n_checked;
        for (int i = 0; i < 8; i++) begin
            if (i % 2 == 0) begin
                apply_cycle(PT_B, KEY_B, 1'b0, 1'b1, CT_B);
            end else begin
                apply_cycle(PT_C, KEY_C, 1'b0, 1'b1, CT_C);
            end
        end
        drain(KEY_C, LATENCY);
        check_value(block_t'(n_checked - start_checked), block_t'(8),
                    "pipelined ciphertexts were not all compared");
    endtask

    //////////////////////////////
    // Run limit
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        rst         <= 1'b1;
        state       <= '0;
        key         <= '0;
        m_armed     = 1'b0;
        m_lfsr      = SEED_VALUE;
        m_leak      = '0;
        n_scheduled = 0;
        n_checked   = 0;
        tick_count  = 0;
        rand_state  = 32'd76639;
        for (int i = 0; i < 512; i++) begin
            exp_valid[i] = 1'b0;
        end

        idle_leak();
        known_answer();
        trigger_run();
        rereset();
        pipelining();

        if (n_checked == n_scheduled) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("Only %0d of %0d ciphertexts were compared", n_checked, n_scheduled);
            $display("Simulation failed");
            $fatal(1, "missing ciphertext checks");
        end
    end

endmodule

// File: compile.f
verilog/aes_pkg.sv
verilog/leak_pkg.sv
verilog/sub_word.sv
verilog/key_expand_stage.sv
verilog/cipher_round.sv
verilog/aes_128_pipe.sv
verilog/leak_channel.sv
verilog/aes_leak_top.sv
testbench/tb_clock.sv
testbench/tb_aes_leak_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the AES leak testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary -f compile.f --top-module tb_aes_leak_top -o sim_tb
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/sim_tb 2>&1)
run_status=$?
echo "$sim_output"

if [ $run_status -ne 0 ]; then
    echo "Simulation binary exited with status $run_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "Simulation passed"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1
